// File: logic/decode_pkg.sv
package decode_pkg;

    // datapath and register index widths
    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned num_regs   = 32;  // 1 << reg_addr_w

    // jal writes its return address here
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b00_0000,  // r-type, look at funct
        op_jal     = 6'b00_0011,
        op_beq     = 6'b00_0100,
        op_bne     = 6'b00_0101,
        op_addiu   = 6'b00_1001,
        op_slti    = 6'b00_1010,
        op_sltiu   = 6'b00_1011,
        op_ori     = 6'b00_1101,
        op_lui     = 6'b00_1111,
        op_lw      = 6'b10_0011,
        op_sw      = 6'b10_1011
    } opcode_e;

    // special function field, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'b00_0000,
        fn_jr   = 6'b00_1000,
        fn_addu = 6'b10_0001,
        fn_subu = 6'b10_0011,
        fn_or   = 6'b10_0101,
        fn_xor  = 6'b10_0110,
        fn_slt  = 6'b10_1010,
        fn_sltu = 6'b10_1011
    } funct_e;

    // operation carried to EX
    typedef enum logic [3:0] {
        alu_nop,   // idle slot or no result
        alu_add,
        alu_sub,
        alu_slt,   // signed compare
        alu_sltu,  // unsigned compare
        alu_or,
        alu_xor,
        alu_sll,   // src2 shifted by src1
        alu_lui    // src2 moved to upper half
    } alu_op_e;

    // first alu operand
    typedef enum logic [1:0] {
        src1_rs,  // forwarded rs value
        src1_pc,  // pc of this slot, for jal
        src1_sa   // shift amount field
    } src1_sel_e;

    // second alu operand
    typedef enum logic [1:0] {
        src2_rt,        // forwarded rt value
        src2_imm_sext,  // sign extended imm16
        src2_const8,    // link offset, skips the delay slot
        src2_imm_zext   // zero extended imm16, ori only
    } src2_sel_e;

endpackage

// File: logic/if_id_reg.sv
module if_id_reg
    import decode_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_if,  // fetch side frozen
    input  logic            stall_id,  // decode side frozen
    input  logic            if_valid,
    input  logic [xlen-1:0] if_pc,
    output logic            id_valid,
    output logic [xlen-1:0] id_pc
);

    logic load_bubble;
    logic load_next;

    // fetch stops but decode moves on, so decode must see an empty slot
    assign load_bubble = stall_if && !stall_id;
    assign load_next   = !stall_if;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            id_pc    <= '0;
        end else if (load_bubble) begin
            id_valid <= 1'b0;  // bubble
            id_pc    <= '0;
        end else if (load_next) begin
            id_valid <= if_valid;
            id_pc    <= if_pc;
        end
        // both stalled: hold
    end

    // a bubble must show up as an idle slot on the next edge
    a_bubble_idle: assert property (
        @(posedge clk) disable iff (rst) load_bubble |=> !id_valid
    ) else $error("if_id_reg: valid slot after bubble");

endmodule

// File: logic/inst_decoder.sv
module inst_decoder
    import decode_pkg::*;
(
    input  logic                  id_valid,
    input  logic [xlen-1:0]       inst,
    output alu_op_e               alu_op,
    output src1_sel_e             src1_sel,
    output src2_sel_e             src2_sel,
    output logic                  mem_en,       // lw or sw
    output logic                  mem_we,       // sw only
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic                  rf_from_mem,  // writeback takes load data
    output logic [reg_addr_w-1:0] rs,
    output logic [reg_addr_w-1:0] rt,
    output logic                  is_beq,
    output logic                  is_bne,
    output logic                  is_jr,
    output logic                  is_jal
);

    opcode_e               opcode;
    funct_e                funct;
    logic [reg_addr_w-1:0] rd;

    // instruction fields
    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];

    always_comb begin
        // idle defaults, also used for unknown encodings
        alu_op      = alu_nop;
        src1_sel    = src1_rs;
        src2_sel    = src2_rt;
        mem_en      = 1'b0;
        mem_we      = 1'b0;
        rf_we       = 1'b0;
        rf_waddr    = '0;
        rf_from_mem = 1'b0;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        is_jr       = 1'b0;
        is_jal      = 1'b0;

        if (id_valid) begin
            case (opcode)
                op_special: begin
                    rf_we    = 1'b1;  // r-type writes rd
                    rf_waddr = rd;
                    case (funct)
                        fn_addu: alu_op = alu_add;
                        fn_subu: alu_op = alu_sub;
                        fn_or:   alu_op = alu_or;
                        fn_xor:  alu_op = alu_xor;
                        fn_slt:  alu_op = alu_slt;
                        fn_sltu: alu_op = alu_sltu;
                        fn_sll: begin
                            alu_op   = alu_sll;
                            src1_sel = src1_sa;  // rt << sa
                        end
                        fn_jr: begin
                            is_jr = 1'b1;  // no result
                            rf_we = 1'b0;
                            rf_waddr = '0;
                        end
                        default: begin
                            rf_we    = 1'b0;  // unknown funct
                            rf_waddr = '0;
                        end
                    endcase
                end
                op_addiu, op_slti, op_sltiu, op_ori, op_lui: begin
                    rf_we    = 1'b1;  // immediate forms write rt
                    rf_waddr = rt;
                    src2_sel = src2_imm_sext;
                    case (opcode)
                        op_slti:  alu_op = alu_slt;
                        op_sltiu: alu_op = alu_sltu;
                        op_lui:   alu_op = alu_lui;
                        op_ori: begin
                            alu_op   = alu_or;
                            src2_sel = src2_imm_zext;  // logical imm
                        end
                        default:  alu_op = alu_add;  // addiu
                    endcase
                end
                op_lw: begin
                    alu_op      = alu_add;  // base + offset
                    src2_sel    = src2_imm_sext;
                    mem_en      = 1'b1;
                    rf_we       = 1'b1;
                    rf_waddr    = rt;
                    rf_from_mem = 1'b1;
                end
                op_sw: begin
                    alu_op   = alu_add;
                    src2_sel = src2_imm_sext;
                    mem_en   = 1'b1;
                    mem_we   = 1'b1;
                end
                op_beq: is_beq = 1'b1;  // resolved in branch_unit
                op_bne: is_bne = 1'b1;
                op_jal: begin
                    is_jal   = 1'b1;
                    alu_op   = alu_add;  // pc + 8 into link reg
                    src1_sel = src1_pc;
                    src2_sel = src2_const8;
                    rf_we    = 1'b1;
                    rf_waddr = link_reg;
                end
                default: ;  // unknown opcode stays idle
            endcase
        end
    end

    // a single slot never writes both the register file and memory
    a_one_write: assert final (!(rf_we && mem_we))
        else $error("inst_decoder: rf_we and mem_we both set");

endmodule

// File: logic/regfile.sv
module regfile
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic                  we,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [num_regs];

    // write port, from writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // r0 never written
            regs[waddr] <= wdata;
        end
    end

    // async reads, r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // a write lands by the next edge and is visible on a matching read
    a_write_visible: assert property (
        @(posedge clk) disable iff (rst)
        (we && waddr != '0 && raddr1 == waddr) ##1 (raddr1 == $past(waddr))
            |-> rdata1 == $past(wdata)
    ) else $error("regfile: written value not read back");

endmodule

// File: logic/operand_bypass.sv
module operand_bypass
    import decode_pkg::*;
(
    input  logic [reg_addr_w-1:0] src_addr,  // rs or rt of this slot
    input  logic [xlen-1:0]       rf_data,   // raw register file read
    input  logic                  ex_we,
    input  logic [reg_addr_w-1:0] ex_waddr,
    input  logic [xlen-1:0]       ex_wdata,
    input  logic                  mem_we,
    input  logic [reg_addr_w-1:0] mem_waddr,
    input  logic [xlen-1:0]       mem_wdata,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_waddr,
    input  logic [xlen-1:0]       wb_wdata,
    output logic [xlen-1:0]       src_data
);

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // a stage matches when it writes the register we read
    assign ex_hit  = ex_we  && (ex_waddr  == src_addr);
    assign mem_hit = mem_we && (mem_waddr == src_addr);
    assign wb_hit  = wb_we  && (wb_waddr  == src_addr);

    // youngest producer wins
    always_comb begin
        if (src_addr == '0) begin
            src_data = '0;  // r0, ignore any bypass
        end else if (ex_hit) begin
            src_data = ex_wdata;
        end else if (mem_hit) begin
            src_data = mem_wdata;
        end else if (wb_hit) begin
            src_data = wb_wdata;  // covers same-cycle rf write
        end else begin
            src_data = rf_data;
        end
    end

endmodule

// File: logic/branch_unit.sv
module branch_unit
    import decode_pkg::*;
(
    input  logic [xlen-1:0] id_pc,
    input  logic [xlen-1:0] inst,
    input  logic [xlen-1:0] rs_data,  // forwarded
    input  logic [xlen-1:0] rt_data,  // forwarded
    input  logic            is_beq,   // flags already qualified by valid
    input  logic            is_bne,
    input  logic            is_jr,
    input  logic            is_jal,
    output logic            br_taken,
    output logic [xlen-1:0] br_target
);

    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] br_offset;
    logic [xlen-1:0] jump_addr;
    logic            rs_eq_rt;

    assign pc_plus_4 = id_pc + 32'd4;  // delay slot pc
    assign rs_eq_rt  = (rs_data == rt_data);

    // imm16 sign extended, word aligned
    assign br_offset = {{14{inst[15]}}, inst[15:0], 2'b00};
    // j-type region jump, stays in the current 256MB segment
    assign jump_addr = {pc_plus_4[31:28], inst[25:0], 2'b00};

    always_comb begin
        br_taken  = 1'b0;
        br_target = '0;  // zero when not taken
        if (is_beq && rs_eq_rt) begin
            br_taken  = 1'b1;
            br_target = pc_plus_4 + br_offset;
        end else if (is_bne && !rs_eq_rt) begin
            br_taken  = 1'b1;
            br_target = pc_plus_4 + br_offset;
        end else if (is_jr) begin
            br_taken  = 1'b1;
            br_target = rs_data;  // register target
        end else if (is_jal) begin
            br_taken  = 1'b1;
            br_target = jump_addr;
        end
    end

endmodule

// File: logic/decode_stage.sv
module decode_stage
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_if,
    input  logic                  stall_id,
    input  logic                  if_valid,
    input  logic [xlen-1:0]       if_pc,
    input  logic [xlen-1:0]       inst_rdata,  // sram data for the held pc
    // producers for forwarding
    input  logic                  ex_we,
    input  logic [reg_addr_w-1:0] ex_waddr,
    input  logic [xlen-1:0]       ex_wdata,
    input  logic                  mem_we,
    input  logic [reg_addr_w-1:0] mem_waddr,
    input  logic [xlen-1:0]       mem_wdata,
    input  logic                  wb_we,     // also the rf write port
    input  logic [reg_addr_w-1:0] wb_waddr,
    input  logic [xlen-1:0]       wb_wdata,
    // to EX
    output logic [xlen-1:0]       ex_pc,
    output logic [xlen-1:0]       ex_inst,
    output alu_op_e               alu_op,
    output src1_sel_e             src1_sel,
    output src2_sel_e             src2_sel,
    output logic                  mem_en,
    output logic                  dmem_we,   // store to data memory
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic                  rf_from_mem,
    output logic [xlen-1:0]       src1_data,
    output logic [xlen-1:0]       src2_data,
    // to fetch
    output logic                  br_taken,
    output logic [xlen-1:0]       br_target
);

    logic                  id_valid;
    logic [xlen-1:0]       id_pc;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic                  is_beq;
    logic                  is_bne;
    logic                  is_jr;
    logic                  is_jal;

    assign ex_pc   = id_pc;
    assign ex_inst = inst_rdata;  // no extra stage on the instruction

    if_id_reg u_if_id_reg (
        .clk      (clk),
        .rst      (rst),
        .stall_if (stall_if),
        .stall_id (stall_id),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .id_valid (id_valid),
        .id_pc    (id_pc)
    );

    inst_decoder u_inst_decoder (
        .id_valid    (id_valid),
        .inst        (inst_rdata),
        .alu_op      (alu_op),
        .src1_sel    (src1_sel),
        .src2_sel    (src2_sel),
        .mem_en      (mem_en),
        .mem_we      (dmem_we),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_from_mem (rf_from_mem),
        .rs          (rs),
        .rt          (rt),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_jr       (is_jr),
        .is_jal      (is_jal)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rs),
        .raddr2 (rt),
        .waddr  (wb_waddr),
        .we     (wb_we),
        .wdata  (wb_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // rs path
    operand_bypass u_bypass_rs (
        .src_addr  (rs),
        .rf_data   (rf_rdata1),
        .ex_we     (ex_we),
        .ex_waddr  (ex_waddr),
        .ex_wdata  (ex_wdata),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .wb_we     (wb_we),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata),
        .src_data  (src1_data)
    );

    // rt path
    operand_bypass u_bypass_rt (
        .src_addr  (rt),
        .rf_data   (rf_rdata2),
        .ex_we     (ex_we),
        .ex_waddr  (ex_waddr),
        .ex_wdata  (ex_wdata),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .wb_we     (wb_we),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata),
        .src_data  (src2_data)
    );

    branch_unit u_branch_unit (
        .id_pc     (id_pc),
        .inst      (inst_rdata),
        .rs_data   (src1_data),
        .rt_data   (src2_data),
        .is_beq    (is_beq),
        .is_bne    (is_bne),
        .is_jr     (is_jr),
        .is_jal    (is_jal),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

// File: bench/decode_stage_tb.sv
module decode_stage_tb
    import decode_pkg::*;
();

    localparam int clk_period  = 40;
    localparam int drive_delay = 2;     // input change point after the rising edge
    localparam int n_random    = 400;   // random decode slots
    localparam int max_cycles  = 2000;  // about four times the ~500 cycles the tests take

    // one entry per kept instruction
    localparam int n_kinds = 18;
    localparam int k_jr    = 7;
    localparam int k_lw    = 13;
    localparam int k_sw    = 14;
    localparam int k_beq   = 15;
    localparam int k_bne   = 16;
    localparam int k_jal   = 17;

    localparam logic [7:0] idle_ctrl = {4'(alu_nop), 4'b0000};

    logic                  clk;
    logic                  rst;
    logic                  stall_if;
    logic                  stall_id;
    logic                  if_valid;
    logic [xlen-1:0]       if_pc;
    logic [xlen-1:0]       inst_rdata;
    logic                  ex_we;
    logic [reg_addr_w-1:0] ex_waddr;
    logic [xlen-1:0]       ex_wdata;
    logic                  mem_we;       // MEM stage producer
    logic [reg_addr_w-1:0] mem_waddr;
    logic [xlen-1:0]       mem_wdata;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_waddr;
    logic [xlen-1:0]       wb_wdata;

    logic [xlen-1:0]       ex_pc;
    logic [xlen-1:0]       ex_inst;
    alu_op_e               alu_op;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    logic                  mem_en;
    logic                  dec_mem_we;   // store strobe from decode
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic                  rf_from_mem;
    logic [xlen-1:0]       src1_data;
    logic [xlen-1:0]       src2_data;
    logic                  br_taken;
    logic [xlen-1:0]       br_target;

    // shadow of the IF/ID register and the register file
    logic                  model_ready = 1'b0;
    logic                  model_valid;
    logic [xlen-1:0]       model_pc;
    logic [xlen-1:0]       model_regs [32];
    logic [xlen-1:0]       prev_if_pc;
    logic [xlen-1:0]       prev_ex_pc;
    logic [7:0]            ctrl_bits;

    integer                seed;
    int                    cycle_count = 0;
    string                 test_name;
    logic [xlen-1:0]       pending_inst;  // sram word for the pc just presented
    logic [n_kinds-1:0]    kind_seen;

    // instruction table, R-type first
    opcode_e   kind_op   [n_kinds] = '{op_special, op_special, op_special, op_special,
                                       op_special, op_special, op_special, op_special,
                                       op_ori, op_lui, op_addiu, op_slti, op_sltiu,
                                       op_lw, op_sw, op_beq, op_bne, op_jal};
    funct_e    kind_fn   [n_kinds] = '{fn_addu, fn_subu, fn_or, fn_xor, fn_sll, fn_slt,
                                       fn_sltu, fn_jr, fn_sll, fn_sll, fn_sll, fn_sll,
                                       fn_sll, fn_sll, fn_sll, fn_sll, fn_sll, fn_sll};
    alu_op_e   kind_alu  [n_kinds] = '{alu_add, alu_sub, alu_or, alu_xor, alu_sll, alu_slt,
                                       alu_sltu, alu_nop, alu_or, alu_lui, alu_add, alu_slt,
                                       alu_sltu, alu_add, alu_add, alu_nop, alu_nop, alu_add};
    src1_sel_e kind_src1 [n_kinds] = '{src1_rs, src1_rs, src1_rs, src1_rs, src1_sa, src1_rs,
                                       src1_rs, src1_rs, src1_rs, src1_rs, src1_rs, src1_rs,
                                       src1_rs, src1_rs, src1_rs, src1_rs, src1_rs, src1_pc};
    src2_sel_e kind_src2 [n_kinds] = '{src2_rt, src2_rt, src2_rt, src2_rt, src2_rt, src2_rt,
                                       src2_rt, src2_rt, src2_imm_zext, src2_imm_sext,
                                       src2_imm_sext, src2_imm_sext, src2_imm_sext,
                                       src2_imm_sext, src2_imm_sext, src2_rt, src2_rt,
                                       src2_const8};
    // destination: 0 none, 1 rd, 2 rt, 3 link
    int        kind_dest [n_kinds] = '{1, 1, 1, 1, 1, 1, 1, 0, 2, 2, 2, 2, 2, 2, 0, 0, 0, 3};

    assign ctrl_bits = {alu_op, rf_we, mem_en, dec_mem_we, br_taken};

    // port order of decode_stage
    decode_stage u_decode_stage (
        clk,
        rst,
        stall_if,
        stall_id,
        if_valid,
        if_pc,
        inst_rdata,
        ex_we,
        ex_waddr,
        ex_wdata,
        mem_we,
        mem_waddr,
        mem_wdata,
        wb_we,
        wb_waddr,
        wb_wdata,
        ex_pc,
        ex_inst,
        alu_op,
        src1_sel,
        src2_sel,
        mem_en,
        dec_mem_we,
        rf_we,
        rf_waddr,
        rf_from_mem,
        src1_data,
        src2_data,
        br_taken,
        br_target
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act)
            else fail_run($sformatf("Mismatch %s %s expected %h actual %h",
                                    test_name, what, exp, act));
    endtask

    // index into the table, -1 for anything not kept
    function automatic int classify(input logic [31:0] word);
        for (int k = 0; k < n_kinds; k++) begin
            if (word[31:26] == kind_op[k] &&
                (kind_op[k] != op_special || word[5:0] == kind_fn[k])) begin
                return k;
            end
        end
        return -1;
    endfunction

    // operand value after forwarding, youngest stage first
    function automatic logic [31:0] forwarded(input logic [4:0] a);
        if (a == 5'd0) return '0;
        if (ex_we && ex_waddr == a) return ex_wdata;
        if (mem_we && mem_waddr == a) return mem_wdata;
        if (wb_we && wb_waddr == a) return wb_wdata;
        return model_regs[a];
    endfunction

    // shadow state, same edge as the DUT
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        prev_if_pc  <= if_pc;
        prev_ex_pc  <= ex_pc;
        if (rst) begin
            model_ready <= 1'b1;
            model_valid <= 1'b0;
            model_pc    <= '0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] <= '0;
            end
        end else begin
            if (stall_if && !stall_id) begin
                model_valid <= 1'b0;  // bubble
                model_pc    <= '0;
            end else if (!stall_if) begin
                model_valid <= if_valid;
                model_pc    <= if_pc;
            end
            if (wb_we && wb_waddr != 5'd0) begin
                model_regs[wb_waddr] <= wb_wdata;
            end
        end
        if (cycle_count >= max_cycles) begin
            fail_run("run did not finish within the cycle limit");
        end
    end

    task automatic compare_outputs();
        int          kind;
        alu_op_e     e_alu;
        src1_sel_e   e_src1;
        src2_sel_e   e_src2;
        logic        e_rf_we;
        logic [4:0]  e_waddr;
        logic        e_taken;
        logic [31:0] e_rs;
        logic [31:0] e_rt;
        logic [31:0] e_target;
        logic [31:0] pc4;
        kind     = model_valid ? classify(inst_rdata) : -1;
        e_alu    = alu_nop;   // idle slot
        e_src1   = src1_rs;
        e_src2   = src2_rt;
        e_rf_we  = 1'b0;
        e_waddr  = '0;
        e_taken  = 1'b0;
        e_target = '0;
        e_rs     = forwarded(inst_rdata[25:21]);
        e_rt     = forwarded(inst_rdata[20:16]);
        pc4      = model_pc + 32'd4;
        if (kind >= 0) begin
            kind_seen[kind] = 1'b1;
            e_alu  = kind_alu[kind];
            e_src1 = kind_src1[kind];
            e_src2 = kind_src2[kind];
            e_rf_we = kind_dest[kind] != 0;
            case (kind_dest[kind])
                1:       e_waddr = inst_rdata[15:11];
                2:       e_waddr = inst_rdata[20:16];
                3:       e_waddr = link_reg;
                default: e_waddr = '0;
            endcase
        end
        // branch resolution
        if ((kind == k_beq && e_rs == e_rt) || (kind == k_bne && e_rs != e_rt)) begin
            e_taken  = 1'b1;
            e_target = pc4 + {{14{inst_rdata[15]}}, inst_rdata[15:0], 2'b00};
        end else if (kind == k_jr) begin
            e_taken  = 1'b1;
            e_target = e_rs;
        end else if (kind == k_jal) begin
            e_taken  = 1'b1;
            e_target = {pc4[31:28], inst_rdata[25:0], 2'b00};
        end
        check_value("ex_pc", model_pc, ex_pc);
        check_value("ex_inst", inst_rdata, ex_inst);
        check_value("alu_op", e_alu, alu_op);
        check_value("src1_sel", e_src1, src1_sel);
        check_value("src2_sel", e_src2, src2_sel);
        check_value("rf_we", e_rf_we, rf_we);
        check_value("rf_waddr", e_waddr, rf_waddr);
        check_value("mem_en", kind == k_lw || kind == k_sw, mem_en);
        check_value("mem_we", kind == k_sw, dec_mem_we);
        check_value("rf_from_mem", kind == k_lw, rf_from_mem);
        check_value("src1_data", e_rs, src1_data);
        check_value("src2_data", e_rt, src2_data);
        check_value("br_taken", e_taken, br_taken);
        check_value("br_target", e_target, br_target);
    endtask

    // outputs settled mid cycle
    always @(negedge clk) begin
        if (model_ready) begin
            compare_outputs();
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> ctrl_bits == idle_ctrl)
        else fail_run($sformatf("Mismatch reset controls expected %h actual %h",
                                idle_ctrl, $sampled(ctrl_bits)));

    a_bubble_idle: assert property (
        @(posedge clk) disable iff (rst)
        (stall_if && !stall_id) |=> (ctrl_bits == idle_ctrl && ex_pc == '0)
    ) else fail_run($sformatf("Mismatch bubble ctrl_pc expected %h_%h actual %h_%h",
                              idle_ctrl, 32'h0, $sampled(ctrl_bits), $sampled(ex_pc)));

    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst) (stall_if && stall_id) |=> ex_pc == prev_ex_pc
    ) else fail_run($sformatf("Mismatch stall_hold ex_pc expected %h actual %h",
                              $sampled(prev_ex_pc), $sampled(ex_pc)));

    a_pc_follow: assert property (
        @(posedge clk) disable iff (rst) !stall_if |=> ex_pc == prev_if_pc
    ) else fail_run($sformatf("Mismatch pc_follow ex_pc expected %h actual %h",
                              $sampled(prev_if_pc), $sampled(ex_pc)));

    task automatic clear_producers();
        ex_we     = 1'b0;
        ex_waddr  = '0;
        ex_wdata  = '0;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        wb_we     = 1'b0;
        wb_waddr  = '0;
        wb_wdata  = '0;
    endtask

    task automatic randomize_producers();
        ex_we     = $random(seed);
        ex_waddr  = $random(seed) & 7;  // low regs, so hits happen
        ex_wdata  = $random(seed);
        mem_we    = $random(seed);
        mem_waddr = $random(seed) & 7;
        mem_wdata = $random(seed);
        wb_we     = $random(seed);
        wb_waddr  = $random(seed) & 7;
        wb_wdata  = $random(seed);
    endtask

    // present a pc; its word shows up on inst_rdata one cycle later
    task automatic step(input logic valid, input logic [31:0] pc, input logic [31:0] word);
        @(posedge clk);
        #drive_delay;
        inst_rdata   = pending_inst;
        if_valid     = valid;
        if_pc        = pc;
        pending_inst = word;
    endtask

    // stalled cycle, fetch side keeps moving
    task automatic hold_cycle(input logic s_if, input logic s_id);
        @(posedge clk);
        #drive_delay;
        stall_if = s_if;
        stall_id = s_id;
        if_pc    = $random(seed) & 32'hffff_fffc;
    endtask

    task automatic make_inst(output logic [31:0] word);
        int          k;
        int          pick;
        logic [31:0] bits;
        k    = ($random(seed) & 32'h7fff_ffff) % n_kinds;
        pick = $random(seed) & 15;
        bits = $random(seed);
        if (pick == 0) begin
            word = bits;  // any encoding, mostly unknown
        end else if (kind_op[k] == op_special) begin
            word = {6'b00_0000, bits[25:6], kind_fn[k]};
        end else begin
            word = {kind_op[k], bits[25:0]};
        end
    endtask

    // producers drive rs and rt in the slot where the branch decodes
    task automatic branch_case(input logic [31:0] pc, input logic [31:0] word,
                               input logic [31:0] rs_val, input logic [31:0] rt_val);
        step(1'b1, pc, word);
        step(1'b0, '0, '0);
        ex_we     = 1'b1;
        ex_waddr  = word[25:21];
        ex_wdata  = rs_val;
        mem_we    = 1'b1;
        mem_waddr = word[20:16];
        mem_wdata = rt_val;
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] a;
        logic        v;
        seed         = 32'h07f2945b;
        clk          = 1'b0;
        rst          = 1'b1;
        stall_if     = 1'b0;
        stall_id     = 1'b0;
        if_valid     = 1'b1;  // live lw offered during reset, must not decode
        if_pc        = 32'h0000_0040;
        inst_rdata   = {op_lw, 5'd1, 5'd2, 16'h0004};
        pending_inst = '0;
        kind_seen    = '0;
        clear_producers();
        test_name = "reset";
        repeat (10) @(posedge clk);
        #drive_delay;
        rst      = 1'b0;
        if_valid = 1'b0;
        if_pc    = '0;
        step(1'b0, '0, '0);  // idle slot right after reset
        step(1'b0, '0, '0);

        test_name = "decode";
        for (int i = 0; i < n_random; i++) begin
            make_inst(word);
            v  = ($random(seed) & 7) != 0;  // mostly valid slots
            pc = $random(seed) & 32'hffff_fffc;
            step(v, pc, word);
            randomize_producers();
        end
        step(1'b0, '0, '0);
        clear_producers();
        step(1'b0, '0, '0);

        test_name = "regfile";
        for (int r = 0; r < 8; r++) begin  // r0 included
            step(1'b0, '0, '0);
            wb_we    = 1'b1;
            wb_waddr = 5'(r);
            wb_wdata = $random(seed);
        end
        step(1'b0, '0, '0);
        clear_producers();
        for (int r = 0; r < 8; r++) begin
            step(1'b1, 32'h400 + 4 * r, {6'b0, 5'(r), 5'(7 - r), 5'd10, 5'd0, fn_addu});
        end
        step(1'b0, '0, '0);
        step(1'b0, '0, '0);

        test_name = "bypass";
        word = {6'b0, 5'd5, 5'd5, 5'd3, 5'd0, fn_addu};  // addu r3, r5, r5
        step(1'b1, 32'h100, word);
        step(1'b1, 32'h104, word);
        ex_we     = 1'b1;
        ex_waddr  = 5'd5;
        ex_wdata  = 32'h1111_0001;
        mem_we    = 1'b1;
        mem_waddr = 5'd5;
        mem_wdata = 32'h2222_0002;
        wb_we     = 1'b1;
        wb_waddr  = 5'd5;
        wb_wdata  = 32'h3333_0003;
        step(1'b1, 32'h108, word);
        ex_we = 1'b0;   // MEM now wins
        step(1'b0, '0, '0);
        mem_we = 1'b0;  // WB now wins
        step(1'b0, '0, '0);
        clear_producers();

        test_name = "branch";
        a = $random(seed);
        branch_case(32'h1000, {op_beq, 5'd6, 5'd7, 16'h0010}, a, a);
        branch_case(32'h1100, {op_beq, 5'd6, 5'd7, 16'hfff0}, a, a ^ 32'h1);
        branch_case(32'h1200, {op_bne, 5'd6, 5'd7, 16'hff80}, a, a);
        branch_case(32'h1300, {op_bne, 5'd6, 5'd7, 16'h0042}, a, ~a);
        branch_case(32'h1400, {6'b0, 5'd6, 15'd0, fn_jr}, a & 32'hffff_fffc, a);
        word = $random(seed);
        branch_case(32'ha000_0040, {op_jal, word[25:0]}, a, a);
        step(1'b0, '0, '0);
        clear_producers();
        step(1'b0, '0, '0);

        test_name = "stall";
        step(1'b1, 32'h2000, {6'b0, 5'd1, 5'd2, 5'd3, 5'd0, fn_addu});
        step(1'b1, 32'h2004, {op_ori, 5'd1, 5'd4, 16'h8001});
        step(1'b1, 32'h3000, '0);  // ori decodes here, then held
        stall_if = 1'b1;
        stall_id = 1'b1;
        repeat (3) hold_cycle(1'b1, 1'b1);
        hold_cycle(1'b1, 1'b0);    // bubble on the next edge
        step(1'b1, 32'h3008, {op_lw, 5'd2, 5'd9, 16'h0004});
        stall_if = 1'b0;
        stall_id = 1'b0;
        step(1'b1, 32'h300c, {op_sw, 5'd2, 5'd9, 16'h0008});
        step(1'b0, '0, '0);
        step(1'b0, '0, '0);
        step(1'b0, '0, '0);

        if (kind_seen != '1) begin
            fail_run("not every kept instruction reached decode");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: decode_stage.f
logic/decode_pkg.sv
logic/if_id_reg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/decode_stage.sv
bench/decode_stage_tb.sv

// File: Bender.yml
package:
  name: decode_stage

dependencies: {}

sources:
  - logic/decode_pkg.sv
  - logic/if_id_reg.sv
  - logic/inst_decoder.sv
  - logic/regfile.sv
  - logic/operand_bypass.sv
  - logic/branch_unit.sv
  - logic/decode_stage.sv
  - target: test
    files:
      - bench/decode_stage_tb.sv
